//--- Makefile
# Verilator build and run for the fetch front end

VERILATOR ?= verilator
TOP       ?= tb_fetchTop
RTL_TOP   ?= fetchTop
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ** PASS **
VFLAGS    ?= --timing --assert

.PHONY: all lint lint-rtl build sim clean

all: sim

lint: lint-rtl
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

lint-rtl:
	$(VERILATOR) --lint-only --assert --top-module $(RTL_TOP) \
		fetchPkg.sv pcRegister.sv branchTargetBuffer.sv \
		addrTranslate.sv fetchPacket.sv fetchTop.sv

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF -- "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- addrTranslate.sv
`timescale 1ns/1ps

module addrTranslate (
    input  fetchPkg::word_t vAddr_i,
    output fetchPkg::word_t physAddr_o,
    output logic            cacheable_o
);

    import fetchPkg::*;

    fetchAddr_u vAddr;
    logic isKseg0;
    logic isKseg1;
    logic isKseg;

    // ------------------------------------------------------------------
    // segment decode
    // ------------------------------------------------------------------

    assign vAddr   = vAddr_i;
    assign isKseg0 = vAddr.segView.seg == SEG_KSEG0;
    assign isKseg1 = vAddr.segView.seg == SEG_KSEG1;
    assign isKseg  = isKseg0 | isKseg1;

    // ------------------------------------------------------------------
    // fixed mapping
    // ------------------------------------------------------------------

    // kseg0/kseg1 both window the low 512 MB
    // kuseg and kseg2/3 pass through as there is no tlb
    assign physAddr_o = isKseg ? (vAddr_i & PHYS_MASK) : vAddr_i;

    // only kseg1 bypasses the cache
    assign cacheable_o = ~isKseg1;

endmodule

//--- branchTargetBuffer.sv
`timescale 1ns/1ps

module branchTargetBuffer #(
    parameter int BTB_ENTRIES = 16
) (
    input  logic            clk,
    input  logic            rst,
    input  fetchPkg::word_t fetchVAddr_i,
    input  logic            fetchAccept_i,
    input  logic            inDelaySlotGroup_i,
    input  logic            updValid_i,
    input  fetchPkg::word_t updPc_i,
    input  fetchPkg::word_t updTarget_i,
    output fetchPkg::word_t predictPc_o,
    output logic            needDelaySlot_o
);

    import fetchPkg::*;

    // group address is pc[31:4]
    localparam int IDX_BITS = $clog2(BTB_ENTRIES);
    localparam int TAG_BITS = 28 - IDX_BITS;

    // table, valid bits are the only control state
    logic [BTB_ENTRIES-1:0] entryValid;
    logic [TAG_BITS-1:0]    tagMem [BTB_ENTRIES];
    logic [1:0]             slotMem [BTB_ENTRIES];
    word_t                  targetMem [BTB_ENTRIES];

    // target of a slot-3 branch, used after its delay slot
    word_t pendingTarget;

    fetchAddr_u lookupAddr;
    fetchAddr_u updAddr;
    logic [27:0] lookupGroup;
    logic [27:0] updGroup;
    logic [IDX_BITS-1:0] lookupIdx;
    logic [IDX_BITS-1:0] updIdx;
    logic hit;
    logic slotEnabled;
    logic slotLast;
    word_t seqPc;

    // ------------------------------------------------------------------
    // lookup
    // ------------------------------------------------------------------

    assign lookupAddr  = fetchVAddr_i;
    assign lookupGroup = {lookupAddr.cacheView.tag, lookupAddr.cacheView.set};
    assign lookupIdx   = lookupGroup[IDX_BITS-1:0];

    assign hit = entryValid[lookupIdx] && (tagMem[lookupIdx] == lookupGroup[27:IDX_BITS]);

    // branch must sit at or after the entry word to be fetched
    assign slotEnabled = slotMem[lookupIdx] >= lookupAddr.cacheView.word;
    assign slotLast    = slotMem[lookupIdx] == 2'd3;

    // fall through to the next 16-byte group
    assign seqPc = {lookupGroup + 28'd1, 4'b0000};

    always_comb begin
        predictPc_o     = seqPc;
        needDelaySlot_o = 1'b0;
        if (inDelaySlotGroup_i) begin
            predictPc_o = pendingTarget;
        end else if (hit && slotEnabled) begin
            if (slotLast) begin
                // delay slot lives in the next group, fetch it first
                needDelaySlot_o = 1'b1;
            end else begin
                predictPc_o = targetMem[lookupIdx];
            end
        end
    end

    // ------------------------------------------------------------------
    // update and pending target
    // ------------------------------------------------------------------

    assign updAddr  = updPc_i;
    assign updGroup = {updAddr.cacheView.tag, updAddr.cacheView.set};
    assign updIdx   = updGroup[IDX_BITS-1:0];

    always_ff @(posedge clk) begin
        if (!rst) begin
            entryValid <= '0;
        end else if (updValid_i) begin
            entryValid[updIdx] <= 1'b1;
        end
    end

    // direct-mapped, newest update overwrites
    always_ff @(posedge clk) begin
        if (updValid_i) begin
            tagMem[updIdx]    <= updGroup[27:IDX_BITS];
            slotMem[updIdx]   <= updAddr.cacheView.word;
            targetMem[updIdx] <= updTarget_i;
        end
        if (fetchAccept_i && needDelaySlot_o) begin
            pendingTarget <= targetMem[lookupIdx];
        end
    end

    // the accepted slot-3 group is followed by a delay-slot group
    // in pcRegister, and that group never asks for another one
    assert property (@(posedge clk) disable iff (!rst)
        fetchAccept_i && needDelaySlot_o |=> inDelaySlotGroup_i && !needDelaySlot_o);

endmodule

//--- fetchPacket.sv
`timescale 1ns/1ps

module fetchPacket (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fetchAccept_i,
    input  fetchPkg::word_t               physAddr_i,
    input  logic                          cacheable_i,
    input  logic [fetchPkg::INST_NUM-1:0] instEnable_i,
    input  logic                          hasException_i,
    input  fetchPkg::excCode_t            excCode_i,
    output logic                          fetchValid_o,
    output fetchPkg::word_t               fetchPAddr_o,
    output logic                          fetchCached_o,
    output logic [fetchPkg::INST_NUM-1:0] fetchInstEnable_o,
    output logic                          fetchHasExc_o,
    output fetchPkg::excCode_t            fetchExcCode_o
);

    // ------------------------------------------------------------------
    // valid strobe
    // ------------------------------------------------------------------

    // one pulse per accepted group
    always_ff @(posedge clk) begin
        if (!rst) begin
            fetchValid_o <= 1'b0;
        end else begin
            fetchValid_o <= fetchAccept_i;
        end
    end

    // ------------------------------------------------------------------
    // packet fields
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (fetchAccept_i) begin
            // an excepting group carries no address and starts no fill downstream
            if (hasException_i) begin
                fetchPAddr_o  <= '0;
                fetchCached_o <= 1'b0;
            end else begin
                fetchPAddr_o  <= physAddr_i;
                fetchCached_o <= cacheable_i;
            end
            fetchInstEnable_o <= instEnable_i;
            fetchHasExc_o     <= hasException_i;
            fetchExcCode_o    <= excCode_i;
        end
    end

    // an excepting packet never wants a slot
    assert property (@(posedge clk) disable iff (!rst)
        fetchValid_o && fetchHasExc_o |-> fetchInstEnable_o == '0);

endmodule

//--- fetchPkg.sv
package fetchPkg;

    // ------------------------------------------------------------------
    // basic word types
    // ------------------------------------------------------------------

    // data or address word
    typedef logic [31:0] word_t;

    // mips cause.exccode field
    typedef logic [4:0] excCode_t;

    // address error on load or instruction fetch
    localparam excCode_t EXC_ADEL = 5'd4;

    // ------------------------------------------------------------------
    // fetch group geometry
    // ------------------------------------------------------------------

    // four instructions per 16-byte group
    localparam int INST_NUM = 4;

    // cache request index: byte offset, word in group, set
    localparam int INDEX_BITS = 12;

    // one fetch address, read either as a segment or as a cache address
    typedef union packed {
        // fixed-map segment decode
        struct packed {
            logic [2:0]  seg;
            logic [28:0] offset;
        } segView;
        // icache decode, 256 sets of 16-byte lines
        struct packed {
            logic [19:0] tag;
            logic [7:0]  set;
            logic [1:0]  word;
            logic [1:0]  byteOff;
        } cacheView;
    } fetchAddr_u;

    // ------------------------------------------------------------------
    // fixed segment map
    // ------------------------------------------------------------------

    // 0x8000_0000..0x9fff_ffff, unmapped and cached
    localparam logic [2:0] SEG_KSEG0 = 3'b100;

    // 0xa000_0000..0xbfff_ffff, unmapped and uncached
    localparam logic [2:0] SEG_KSEG1 = 3'b101;

    // strips the segment bits off a kseg0/kseg1 address
    localparam word_t PHYS_MASK = 32'h1FFF_FFFF;

endpackage

//--- fetchTop.sv
`timescale 1ns/1ps

module fetchTop #(
    parameter fetchPkg::word_t START_PC    = 32'hBFC0_0000,
    parameter int              BTB_ENTRIES = 16
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            stopFetch_i,
    input  logic                            instIndexOk_i,
    input  logic                            flush_i,
    input  fetchPkg::word_t                 correctPc_i,
    input  logic                            excOccur_i,
    input  fetchPkg::word_t                 excPc_i,
    input  logic                            btbUpdValid_i,
    input  fetchPkg::word_t                 btbUpdPc_i,
    input  fetchPkg::word_t                 btbUpdTarget_i,
    output logic                            instReq_o,
    output logic [fetchPkg::INDEX_BITS-1:0] instIndex_o,
    output fetchPkg::word_t                 fetchVAddr_o,
    output logic                            fetchValid_o,
    output fetchPkg::word_t                 fetchPAddr_o,
    output logic                            fetchCached_o,
    output logic [fetchPkg::INST_NUM-1:0]   fetchInstEnable_o,
    output logic                            fetchHasExc_o,
    output fetchPkg::excCode_t              fetchExcCode_o
);

    import fetchPkg::*;

    // pc to predictor and packet
    logic fetchAccept;
    logic inDelaySlotGroup;
    logic [INST_NUM-1:0] instEnable;
    logic hasException;
    excCode_t excCode;

    // predictor back to pc
    word_t predictPc;
    logic needDelaySlot;

    // translation to packet
    word_t physAddr;
    logic cacheable;

    // ------------------------------------------------------------------
    // pc and prediction loop
    // ------------------------------------------------------------------

    pcRegister #(
        .START_PC(START_PC)
    ) pcRegister_i (
        .clk                (clk),
        .rst                (rst),
        .stopFetch_i        (stopFetch_i),
        .instIndexOk_i      (instIndexOk_i),
        .flush_i            (flush_i),
        .correctPc_i        (correctPc_i),
        .excOccur_i         (excOccur_i),
        .excPc_i            (excPc_i),
        .predictPc_i        (predictPc),
        .needDelaySlot_i    (needDelaySlot),
        .instReq_o          (instReq_o),
        .instIndex_o        (instIndex_o),
        .fetchVAddr_o       (fetchVAddr_o),
        .fetchAccept_o      (fetchAccept),
        .inDelaySlotGroup_o (inDelaySlotGroup),
        .instEnable_o       (instEnable),
        .hasException_o     (hasException),
        .excCode_o          (excCode)
    );

    branchTargetBuffer #(
        .BTB_ENTRIES(BTB_ENTRIES)
    ) branchTargetBuffer_i (
        .clk                (clk),
        .rst                (rst),
        .fetchVAddr_i       (fetchVAddr_o),
        .fetchAccept_i      (fetchAccept),
        .inDelaySlotGroup_i (inDelaySlotGroup),
        .updValid_i         (btbUpdValid_i),
        .updPc_i            (btbUpdPc_i),
        .updTarget_i        (btbUpdTarget_i),
        .predictPc_o        (predictPc),
        .needDelaySlot_o    (needDelaySlot)
    );

    // ------------------------------------------------------------------
    // translation and packet
    // ------------------------------------------------------------------

    addrTranslate addrTranslate_i (
        .vAddr_i     (fetchVAddr_o),
        .physAddr_o  (physAddr),
        .cacheable_o (cacheable)
    );

    fetchPacket fetchPacket_i (
        .clk               (clk),
        .rst               (rst),
        .fetchAccept_i     (fetchAccept),
        .physAddr_i        (physAddr),
        .cacheable_i       (cacheable),
        .instEnable_i      (instEnable),
        .hasException_i    (hasException),
        .excCode_i         (excCode),
        .fetchValid_o      (fetchValid_o),
        .fetchPAddr_o      (fetchPAddr_o),
        .fetchCached_o     (fetchCached_o),
        .fetchInstEnable_o (fetchInstEnable_o),
        .fetchHasExc_o     (fetchHasExc_o),
        .fetchExcCode_o    (fetchExcCode_o)
    );

endmodule

//--- pcRegister.sv
`timescale 1ns/1ps

module pcRegister #(
    parameter fetchPkg::word_t START_PC = 32'hBFC0_0000
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            stopFetch_i,
    input  logic                            instIndexOk_i,
    input  logic                            flush_i,
    input  fetchPkg::word_t                 correctPc_i,
    input  logic                            excOccur_i,
    input  fetchPkg::word_t                 excPc_i,
    input  fetchPkg::word_t                 predictPc_i,
    input  logic                            needDelaySlot_i,
    output logic                            instReq_o,
    output logic [fetchPkg::INDEX_BITS-1:0] instIndex_o,
    output fetchPkg::word_t                 fetchVAddr_o,
    output logic                            fetchAccept_o,
    output logic                            inDelaySlotGroup_o,
    output logic [fetchPkg::INST_NUM-1:0]   instEnable_o,
    output logic                            hasException_o,
    output fetchPkg::excCode_t              excCode_o
);

    import fetchPkg::*;

    // unaligned fetch pc with word bits kept for the enables
    fetchAddr_u pc;
    // request gate that comes up one cycle after reset release
    logic fetchEn;
    logic redirect;
    logic accepted;
    logic pcLoad;
    word_t nextPc;
    logic misaligned;
    logic [INST_NUM-1:0] posEnable;

    // ------------------------------------------------------------------
    // next pc selection
    // ------------------------------------------------------------------

    // exception from writeback beats a branch recovery
    assign redirect = excOccur_i | flush_i;
    assign nextPc   = excOccur_i ? excPc_i :
                      flush_i    ? correctPc_i :
                                   predictPc_i;

    // cache took the index this cycle
    assign accepted      = instReq_o & instIndexOk_i;
    assign pcLoad        = accepted | redirect;
    // a redirect in the same cycle kills the group
    assign fetchAccept_o = accepted & ~redirect;

    always_ff @(posedge clk) begin
        if (!rst) begin
            fetchEn <= 1'b0;
        end else begin
            fetchEn <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc                 <= START_PC;
            inDelaySlotGroup_o <= 1'b0;
        end else if (pcLoad) begin
            pc                 <= nextPc;
            // only a predicted group can be a lone delay slot
            inDelaySlotGroup_o <= needDelaySlot_i & ~redirect;
        end
    end

    // ------------------------------------------------------------------
    // cache request and group decode
    // ------------------------------------------------------------------

    // instruction buffer full holds requests off
    assign instReq_o = fetchEn & ~stopFetch_i;

    // group aligned with byte bits left in for the alignment check
    assign fetchVAddr_o = {pc.cacheView.tag, pc.cacheView.set, 2'b00, pc.cacheView.byteOff};
    assign instIndex_o  = fetchVAddr_o[INDEX_BITS-1:0];

    // slots from the entry word upwards
    assign posEnable = {INST_NUM{1'b1}} << pc.cacheView.word;

    // any byte offset is an address error
    assign misaligned = |pc.cacheView.byteOff;

    always_comb begin
        if (misaligned) begin
            instEnable_o = '0;
        end else if (inDelaySlotGroup_o) begin
            // delay slot only
            instEnable_o = {{(INST_NUM-1){1'b0}}, 1'b1};
        end else begin
            instEnable_o = posEnable;
        end
    end

    assign hasException_o = misaligned;
    assign excCode_o      = misaligned ? EXC_ADEL : '0;

    // a delay-slot group is the aligned next group entered at word 0
    assert property (@(posedge clk) disable iff (!rst)
        inDelaySlotGroup_o |-> (pc.cacheView.word == 2'd0) && !hasException_o);

endmodule

//--- tb_fetchTop.sv
`timescale 1ns/1ps

module tb_fetchTop;

    localparam logic [31:0] START_PC    = 32'hBFC0_0000;
    localparam int          BTB_ENTRIES = 16;
    // cycles any wait may take before it gives up
    localparam int          WAIT_LIMIT  = 50;

    logic        clk;
    logic        rst;
    logic        stopFetch_i;
    logic        instIndexOk_i;
    logic        flush_i;
    logic [31:0] correctPc_i;
    logic        excOccur_i;
    logic [31:0] excPc_i;
    logic        btbUpdValid_i;
    logic [31:0] btbUpdPc_i;
    logic [31:0] btbUpdTarget_i;
    logic        instReq_o;
    logic [11:0] instIndex_o;
    logic [31:0] fetchVAddr_o;
    logic        fetchValid_o;
    logic [31:0] fetchPAddr_o;
    logic        fetchCached_o;
    logic [3:0]  fetchInstEnable_o;
    logic        fetchHasExc_o;
    logic [4:0]  fetchExcCode_o;

    int          errorCount;
    int          checkCount;
    string       testName;
    logic [31:0] lfsrState;
    // pc the fetch unit should sit on between tests
    logic [31:0] expectedPc;

    fetchTop #(
        .START_PC    (START_PC),
        .BTB_ENTRIES (BTB_ENTRIES)
    ) dut_i (
        .clk               (clk),
        .rst               (rst),
        .stopFetch_i       (stopFetch_i),
        .instIndexOk_i     (instIndexOk_i),
        .flush_i           (flush_i),
        .correctPc_i       (correctPc_i),
        .excOccur_i        (excOccur_i),
        .excPc_i           (excPc_i),
        .btbUpdValid_i     (btbUpdValid_i),
        .btbUpdPc_i        (btbUpdPc_i),
        .btbUpdTarget_i    (btbUpdTarget_i),
        .instReq_o         (instReq_o),
        .instIndex_o       (instIndex_o),
        .fetchVAddr_o      (fetchVAddr_o),
        .fetchValid_o      (fetchValid_o),
        .fetchPAddr_o      (fetchPAddr_o),
        .fetchCached_o     (fetchCached_o),
        .fetchInstEnable_o (fetchInstEnable_o),
        .fetchHasExc_o     (fetchHasExc_o),
        .fetchExcCode_o    (fetchExcCode_o)
    );

    // 100 ns clock
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        lfsrNext = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic takeRandom(input int nBits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nBits; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    // fixed mips map where kseg0/kseg1 drop the segment bits
    function automatic logic [31:0] segmentMap(input logic [31:0] vAddr);
        if (vAddr[31:29] == 3'b100 || vAddr[31:29] == 3'b101) begin
            segmentMap = {3'b000, vAddr[28:0]};
        end else begin
            segmentMap = vAddr;
        end
    endfunction

    // wanted slots for each entry word of a group
    function automatic logic [3:0] groupEnables(input logic [1:0] entryWord);
        case (entryWord)
            2'd0:    groupEnables = 4'b1111;
            2'd1:    groupEnables = 4'b1110;
            2'd2:    groupEnables = 4'b1100;
            default: groupEnables = 4'b1000;
        endcase
    endfunction

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Error in %s, %s: expected %h, actual %h",
                     testName, what, expected, actual);
        end
    endtask

    task automatic reportTimeout(input string what);
        errorCount++;
        $display("Timeout in %s: %s", testName, what);
    endtask

    // idle cycles with ok low and no packet
    task automatic gapCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            @(negedge clk);
            checkValue("packet in idle cycle", 32'h0, {31'b0, fetchValid_o});
        end
    endtask

    // one-cycle redirect pulse
    task automatic driveRedirect(input logic doFlush, input logic [31:0] flushPc,
                                 input logic doExc, input logic [31:0] excPc);
        @(posedge clk);
        flush_i     <= doFlush;
        correctPc_i <= flushPc;
        excOccur_i  <= doExc;
        excPc_i     <= excPc;
        @(posedge clk);
        flush_i    <= 1'b0;
        excOccur_i <= 1'b0;
    endtask

    task automatic btbUpdate(input logic [31:0] branchPc, input logic [31:0] target);
        @(posedge clk);
        btbUpdValid_i  <= 1'b1;
        btbUpdPc_i     <= branchPc;
        btbUpdTarget_i <= target;
        @(posedge clk);
        btbUpdValid_i <= 1'b0;
    endtask

    // accept one group at pc and check the packet one cycle later
    task automatic fetchOne(input logic [31:0] pc, input logic delaySlotOnly);
        int          cnt;
        logic [31:0] expVAddr;
        logic [31:0] expPAddr;
        logic [3:0]  expEnable;
        logic        expExc;
        logic        expCached;
        expVAddr = pc & ~32'h0000_000C;
        expExc   = pc[1:0] != 2'b00;
        if (expExc) begin
            // address error wants nothing and fills nothing
            expEnable = 4'b0000;
            expPAddr  = 32'h0;
            expCached = 1'b0;
        end else begin
            expEnable = delaySlotOnly ? 4'b0001 : groupEnables(pc[3:2]);
            expPAddr  = segmentMap(expVAddr);
            expCached = pc[31:29] != 3'b101;
        end
        @(posedge clk);
        instIndexOk_i <= 1'b1;
        cnt = 0;
        @(negedge clk);
        while (!instReq_o && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (cnt >= WAIT_LIMIT) begin
            reportTimeout("instruction request never came up");
        end else begin
            // accept lands on the next rising edge
            checkValue("fetch address", expVAddr, fetchVAddr_o);
            checkValue("request index", {20'h0, expVAddr[11:0]}, {20'h0, instIndex_o});
            @(posedge clk);
            instIndexOk_i <= 1'b0;
            @(negedge clk);
            checkValue("packet valid", 32'h1, {31'b0, fetchValid_o});
            checkValue("packet address", expPAddr, fetchPAddr_o);
            checkValue("packet cached", {31'b0, expCached}, {31'b0, fetchCached_o});
            checkValue("packet enables", {28'b0, expEnable}, {28'b0, fetchInstEnable_o});
            checkValue("packet exception", {31'b0, expExc}, {31'b0, fetchHasExc_o});
            if (expExc) begin
                checkValue("exception code", 32'h4, {27'b0, fetchExcCode_o});
            end
        end
    endtask

    // ------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------

    task automatic testReset;
        testName = "reset";
        repeat (7) begin
            @(posedge clk);
            @(negedge clk);
            checkValue("request in reset", 32'h0, {31'b0, instReq_o});
            checkValue("valid in reset", 32'h0, {31'b0, fetchValid_o});
        end
        @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        checkValue("start address", START_PC, fetchVAddr_o);
        checkValue("start index", {20'h0, START_PC[11:0]}, {20'h0, instIndex_o});
        fetchOne(START_PC, 1'b0);
        // boot rom sits in kseg1
        checkValue("first physical", 32'h1FC0_0000, fetchPAddr_o);
        checkValue("first uncached", 32'h0, {31'b0, fetchCached_o});
        checkValue("first enables", 32'hF, {28'b0, fetchInstEnable_o});
        expectedPc = START_PC + 32'h10;
    endtask

    task automatic testSequential;
        logic [31:0] gap;
        logic [31:0] prevPAddr;
        testName  = "sequential";
        prevPAddr = segmentMap(START_PC);
        for (int i = 0; i < 6; i++) begin
            takeRandom(2, gap);
            gapCycles(gap);
            fetchOne(expectedPc, 1'b0);
            checkValue("physical step", prevPAddr + 32'h10, fetchPAddr_o);
            prevPAddr  = segmentMap(expectedPc);
            expectedPc = expectedPc + 32'h10;
        end
    endtask

    task automatic testBackPressure;
        testName = "back-pressure";
        // stop wins over a high ok
        @(posedge clk);
        stopFetch_i   <= 1'b1;
        instIndexOk_i <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            checkValue("request while stopped", 32'h0, {31'b0, instReq_o});
            checkValue("pc while stopped", expectedPc, fetchVAddr_o);
            checkValue("packet while stopped", 32'h0, {31'b0, fetchValid_o});
            @(posedge clk);
        end
        stopFetch_i   <= 1'b0;
        instIndexOk_i <= 1'b0;
        // cache not taking the index
        repeat (3) begin
            @(negedge clk);
            checkValue("request while not ok", 32'h1, {31'b0, instReq_o});
            checkValue("pc while not ok", expectedPc, fetchVAddr_o);
            checkValue("packet while not ok", 32'h0, {31'b0, fetchValid_o});
            @(posedge clk);
        end
        fetchOne(expectedPc, 1'b0);
        expectedPc = expectedPc + 32'h10;
    endtask

    task automatic testRedirect;
        logic [31:0] r;
        logic [31:0] target;
        testName = "redirect";
        // random kseg0 target entered at word 2
        takeRandom(25, r);
        target = {3'b100, r[24:0], 4'b1000};
        driveRedirect(1'b1, target, 1'b0, 32'h0);
        fetchOne(target, 1'b0);
        checkValue("flush enables", 32'hC, {28'b0, fetchInstEnable_o});
        checkValue("flush cached", 32'h1, {31'b0, fetchCached_o});
        // both at once and the exception target must win
        testName = "exception over flush";
        driveRedirect(1'b1, 32'h8000_0100, 1'b1, 32'hBFC0_0380);
        fetchOne(32'hBFC0_0380, 1'b0);
        expectedPc = 32'hBFC0_0390;
    endtask

    task automatic testMisaligned;
        testName = "misaligned";
        driveRedirect(1'b1, 32'h8000_2002, 1'b0, 32'h0);
        fetchOne(32'h8000_2002, 1'b0);
        checkValue("exception flag", 32'h1, {31'b0, fetchHasExc_o});
        checkValue("exception enables", 32'h0, {28'b0, fetchInstEnable_o});
        checkValue("exception address", 32'h0, fetchPAddr_o);
    endtask

    task automatic testPrediction;
        testName = "predict slot 1";
        btbUpdate(32'h8000_4014, 32'h8000_5000);
        driveRedirect(1'b1, 32'h8000_4010, 1'b0, 32'h0);
        fetchOne(32'h8000_4010, 1'b0);
        fetchOne(32'h8000_5000, 1'b0);
        // slot 3 branch where the delay slot group comes first
        testName = "predict slot 3";
        btbUpdate(32'h8000_602C, 32'h8000_7008);
        driveRedirect(1'b1, 32'h8000_6020, 1'b0, 32'h0);
        fetchOne(32'h8000_6020, 1'b0);
        fetchOne(32'h8000_6030, 1'b1);
        fetchOne(32'h8000_7008, 1'b0);
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------

    initial begin
        rst            = 1'b0;
        stopFetch_i    = 1'b0;
        instIndexOk_i  = 1'b0;
        flush_i        = 1'b0;
        correctPc_i    = 32'h0;
        excOccur_i     = 1'b0;
        excPc_i        = 32'h0;
        btbUpdValid_i  = 1'b0;
        btbUpdPc_i     = 32'h0;
        btbUpdTarget_i = 32'h0;
        errorCount     = 0;
        checkCount     = 0;
        testName       = "init";
        lfsrState      = 32'h37f91d78;
        expectedPc     = START_PC;

        testReset();
        testSequential();
        testBackPressure();
        testRedirect();
        testMisaligned();
        testPrediction();

        $display("%0d errors in %0d checks", errorCount, checkCount);
        if (errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- verilog.f
fetchPkg.sv
pcRegister.sv
branchTargetBuffer.sv
addrTranslate.sv
fetchPacket.sv
fetchTop.sv
tb_fetchTop.sv
